// File: build.f
+incdir+source
+incdir+bench
source/sample_iter_pkg.sv
source/sweep_control.sv
source/sample_column_gen.sv
source/test_iterator.sv
bench/tb_test_iterator.sv

// File: Bender.yml
package:
  name: sample_iter

sources:
  - include_dirs:
      - source
    files:
      - source/sample_iter_pkg.sv
      - source/sweep_control.sv
      - source/sample_column_gen.sv
      - source/test_iterator.sv
  - target: test
    include_dirs:
      - source
      - bench
    files:
      - bench/tb_test_iterator.sv

// File: bench/iter_vectors.svh
/* triangle table for the iterator bench; coordinates are fixed point with
   1024 per pixel, prim words are filled in by add_entry */
`ifndef ITER_VECTORS_SVH
`define ITER_VECTORS_SVH

// one call per triangle, offered in this order
task automatic load_table;
    // x_min, y_min, x_max, y_max, sub code, gap, columns, last x, last y_base, last valid
    // 1x, two rows, top row has only lane 0 inside
    add_entry(0, 0, 3072, 4096, 4'b1000, 2, 8, 3072, 4096, 4'b0001);
    // 4x, single row, box height just short of lane 3
    add_entry(1024, 1024, 2047, 2559, 4'b0100, 0, 2, 1536, 1024, 4'b0111);
    // 16x, box around the origin, back to back
    add_entry(-512, -1024, 256, 1024, 4'b0010, 0, 12, 256, 1024, 4'b0001);
    // 64x, one column wide, full top row
    add_entry(0, 0, 0, 1000, 4'b0001, 3, 2, 0, 512, 4'b1111);
    // degenerate box, a single sample
    add_entry(2048, 2048, 2048, 2048, 4'b1000, 0, 1, 2048, 2048, 4'b0001);
    // 64x, off-grid corner
    add_entry(100, 0, 600, 300, 4'b0001, 1, 4, 484, 0, 4'b0111);
    // 4x, fully negative box
    add_entry(-2048, -3000, -1, -1000, 4'b0100, 0, 4, -512, -3000, 4'b1111);
    // 16x, two by two
    add_entry(0, 0, 511, 2047, 4'b0010, 2, 4, 256, 1024, 4'b1111);
endtask

`endif

// File: bench/tb_test_iterator.sv
/* table-driven bench for test_iterator; expected columns come from a sweep
   model in the bench, prim words are random with a fixed seed */
`timescale 1ns/1ps
`default_nettype none

`include "raster_cfg.svh"

module tb_test_iterator;

    localparam int CMP_W = `RI_SIGFIG * (`RI_VERTS * `RI_AXIS + `RI_COLORS);
    localparam int MAX_VEC = 16;
    localparam int WAIT_LIMIT = 200;

    logic clk = 1'b0;
    logic rst;
    logic tri_valid;
    sample_iter_pkg::box_t box;
    sample_iter_pkg::prim_t prim;
    sample_iter_pkg::sub_code_t sub_sample;
    logic halt;
    sample_iter_pkg::column_t column;

    // triangle table
    int tab_x_min[MAX_VEC];
    int tab_y_min[MAX_VEC];
    int tab_x_max[MAX_VEC];
    int tab_y_max[MAX_VEC];
    logic [3:0] tab_code[MAX_VEC];
    int tab_gap[MAX_VEC];
    int tab_count[MAX_VEC];
    int tab_last_x[MAX_VEC];
    int tab_last_y[MAX_VEC];
    logic [3:0] tab_last_valid[MAX_VEC];
    sample_iter_pkg::prim_t tab_prim[MAX_VEC];
    int n_vec = 0;

    // expected columns with the cycle each one is due
    sample_iter_pkg::column_t exp_col_q[$];
    int exp_cyc_q[$];
    int halt_exp_q[$];

    int seed = 19140;
    int error_count = 0;
    int checked = 0;
    int cycle_cnt = 0;
    int halt_run = 0;
    int halt_want;
    bit abort = 0;
    sample_iter_pkg::column_t mon_col;

    test_iterator i_test_iterator (
        .clk (clk),
        .rst (rst),
        .tri_valid (tri_valid),
        .box (box),
        .prim (prim),
        .sub_sample (sub_sample),
        .halt (halt),
        .column (column)
    );

    always #2 clk = ~clk;

    // edge counter, read at falling edges only
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic compare_value(input string name, input logic [CMP_W-1:0] got,
                                 input logic [CMP_W-1:0] want);
        if (got !== want) begin
            error_count++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, want);
        end
    endtask

    task automatic report_failure(input string msg);
        error_count++;
        $display("%s", msg);
    endtask

    task automatic add_entry(input int x_min, input int y_min, input int x_max,
                             input int y_max, input logic [3:0] code, input int gap,
                             input int count, input int last_x, input int last_y,
                             input logic [3:0] last_valid);
        logic [CMP_W-1:0] p;
        for (int w = 0; w < CMP_W / 32; w++) begin
            p[w*32 +: 32] = $random(seed);
        end
        tab_x_min[n_vec] = x_min;
        tab_y_min[n_vec] = y_min;
        tab_x_max[n_vec] = x_max;
        tab_y_max[n_vec] = y_max;
        tab_code[n_vec] = code;
        tab_gap[n_vec] = gap;
        tab_count[n_vec] = count;
        tab_last_x[n_vec] = last_x;
        tab_last_y[n_vec] = last_y;
        tab_last_valid[n_vec] = last_valid;
        tab_prim[n_vec] = p;
        n_vec++;
    endtask

    `include "iter_vectors.svh"

    // sub-sample spacing: 1x a pixel, each finer code halves it
    function automatic int step_for_code(input logic [3:0] code);
        case (code)
            4'b1000: step_for_code = 1 << `RI_RADIX;
            4'b0100: step_for_code = 1 << (`RI_RADIX - 1);
            4'b0010: step_for_code = 1 << (`RI_RADIX - 2);
            default: step_for_code = 1 << (`RI_RADIX - 3);
        endcase
    endfunction

    // sweep model, right then up, four lanes per column
    task automatic build_expected(input int e, input int acc_cycle);
        int s;
        int x;
        int y;
        int lane;
        int n;
        bit more;
        sample_iter_pkg::column_t c;
        s = step_for_code(tab_code[e]);
        x = tab_x_min[e];
        y = tab_y_min[e];
        n = 0;
        more = 1;
        while (more && n < 4096) begin
            c.x = x[`RI_SIGFIG-1:0];
            for (int k = 0; k < `RI_LANES; k++) begin
                lane = y + k * s;
                c.y[k] = lane[`RI_SIGFIG-1:0];
                c.valid[k] = (lane <= tab_y_max[e]);
            end
            c.prim = tab_prim[e];
            exp_col_q.push_back(c);
            exp_cyc_q.push_back(acc_cycle + 1 + n);
            n++;
            if (x + s <= tab_x_max[e]) begin
                x = x + s;
            end else if (y + 4 * s <= tab_y_max[e]) begin
                x = tab_x_min[e];
                y = y + 4 * s;
            end else begin
                more = 0;
            end
        end
        // table and model must agree before the DUT is judged
        compare_value("table column count", n, tab_count[e]);
        compare_value("table last x", $unsigned(c.x), $unsigned(tab_last_x[e][`RI_SIGFIG-1:0]));
        compare_value("table last y_base", $unsigned(c.y[0]),
                      $unsigned(tab_last_y[e][`RI_SIGFIG-1:0]));
        compare_value("table last valid", c.valid, tab_last_valid[e]);
        halt_exp_q.push_back(tab_count[e]);
    endtask

    task automatic wait_halt_low(output bit ok);
        int n;
        ok = 0;
        n = 0;
        while (!ok && n < WAIT_LIMIT) begin
            @(negedge clk);
            if (!halt) begin
                ok = 1;
            end
            n++;
        end
        if (!ok) begin
            report_failure("timeout: halt never dropped");
        end
    endtask

    task automatic offer_entry(input int e);
        bit ok;
        int lo;
        int hi;
        ok = 1;
        lo = -4096;
        hi = 4096;
        if (tab_gap[e] > 0) begin
            wait_halt_low(ok);
            repeat (tab_gap[e]) @(posedge clk);
        end
        if (ok) begin
            @(posedge clk);
            box.x_min <= tab_x_min[e][`RI_SIGFIG-1:0];
            box.y_min <= tab_y_min[e][`RI_SIGFIG-1:0];
            box.x_max <= tab_x_max[e][`RI_SIGFIG-1:0];
            box.y_max <= tab_y_max[e][`RI_SIGFIG-1:0];
            prim <= tab_prim[e];
            sub_sample <= tab_code[e];
            tri_valid <= 1'b1;
            // offer held until the FSM is back in wait
            wait_halt_low(ok);
        end
        if (ok) begin
            // next edge accepts
            build_expected(e, cycle_cnt + 1);
            @(posedge clk);
            // second offer during the walk, must be dropped
            box.x_min <= lo[`RI_SIGFIG-1:0];
            box.y_min <= lo[`RI_SIGFIG-1:0];
            box.x_max <= hi[`RI_SIGFIG-1:0];
            box.y_max <= hi[`RI_SIGFIG-1:0];
            prim <= ~tab_prim[e];
            sub_sample <= 4'b0001;
            tri_valid <= 1'b1;
            @(posedge clk);
            tri_valid <= 1'b0;
        end
        if (!ok) begin
            abort = 1;
        end
    endtask

    task automatic drain;
        bit ok;
        int n;
        n = 0;
        wait_halt_low(ok);
        while (exp_col_q.size() > 0 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        // a few idle cycles to catch stray columns
        repeat (4) @(negedge clk);
        if (exp_col_q.size() > 0) begin
            report_failure($sformatf("%0d expected columns never appeared", exp_col_q.size()));
        end
        if (halt_exp_q.size() > 0) begin
            report_failure("a triangle was offered but halt never went high for it");
        end
    endtask

    // column monitor, falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (exp_cyc_q.size() > 0 && exp_cyc_q[0] == cycle_cnt) begin
                mon_col = exp_col_q.pop_front();
                exp_cyc_q.delete(0);
                compare_value("column.valid", column.valid, mon_col.valid);
                compare_value("column.x", $unsigned(column.x), $unsigned(mon_col.x));
                compare_value("column.y", column.y, mon_col.y);
                compare_value("column.prim", column.prim, mon_col.prim);
                checked++;
            end else if (column.valid != '0) begin
                report_failure($sformatf("unexpected column at cycle %0d", cycle_cnt));
            end
        end
    end

    // halt length per triangle
    always @(negedge clk) begin
        if (rst) begin
            halt_run = 0;
        end else if (halt) begin
            halt_run = halt_run + 1;
        end else if (halt_run > 0) begin
            if (halt_exp_q.size() == 0) begin
                report_failure("halt went high with no triangle accepted");
            end else begin
                halt_want = halt_exp_q.pop_front();
                compare_value("halt cycles", halt_run, halt_want);
            end
            halt_run = 0;
        end
    end

    initial begin
        rst = 1'b1;
        tri_valid = 1'b0;
        box = '0;
        prim = '0;
        sub_sample = 4'b1000;
        load_table();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        // idle outputs after reset
        @(negedge clk);
        compare_value("halt", halt, 1'b0);
        compare_value("column.valid", column.valid, 4'b0000);
        for (int e = 0; e < n_vec && !abort; e++) begin
            offer_entry(e);
        end
        if (!abort) begin
            drain();
        end
        $display("errors: %0d, columns checked: %0d", error_count, checked);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/test_iterator.sv
/* no downstream back-pressure; columns leave one cycle after their origin,
   halt is high while a triangle is being walked */
`timescale 1ns/1ps
`default_nettype none

module test_iterator (
    input logic clk,
    input logic rst,
    input logic tri_valid,
    input sample_iter_pkg::box_t box,
    input sample_iter_pkg::prim_t prim,
    input sample_iter_pkg::sub_code_t sub_sample,
    output logic halt,
    output sample_iter_pkg::column_t column
);

    // column origin between the two stages
    sample_iter_pkg::sweep_t sweep;

    // FSM and origin stepping
    sweep_control i_sweep_control (
        .clk (clk),
        .rst (rst),
        .tri_valid (tri_valid),
        .box (box),
        .prim (prim),
        .sub_sample (sub_sample),
        .halt (halt),
        .sweep (sweep)
    );

    // four-lane expansion and output register
    sample_column_gen i_sample_column_gen (
        .clk (clk),
        .rst (rst),
        .sweep (sweep),
        .column (column)
    );

endmodule

`default_nettype wire

// File: source/sample_column_gen.sv
/* one cycle from origin to column; lanes above y_max come out invalid,
   positions and payload are not cleared between triangles */
`timescale 1ns/1ps
`default_nettype none

`include "raster_cfg.svh"

module sample_column_gen (
    input logic clk,
    input logic rst,
    input sample_iter_pkg::sweep_t sweep,
    output sample_iter_pkg::column_t column
);

    // expanded lanes, before the register
    sample_iter_pkg::coord_t [`RI_LANES-1:0] lane_y;
    logic [`RI_LANES-1:0] lane_ok;

    // output registers
    sample_iter_pkg::coord_t col_x_q;
    sample_iter_pkg::coord_t [`RI_LANES-1:0] col_y_q;
    logic [`RI_LANES-1:0] col_valid_q;
    sample_iter_pkg::prim_t col_prim_q;

    // lanes stacked one step apart, bottom lane at the origin
    always_comb begin
        lane_y[0] = sweep.y_base;
        for (int k = 1; k < `RI_LANES; k++) begin
            lane_y[k] = lane_y[k-1] + sweep.step;
        end
    end

    // each lane judged on its own y only
    always_comb begin
        for (int k = 0; k < `RI_LANES; k++) begin
            lane_ok[k] = sweep.active && (lane_y[k] <= sweep.y_max);
        end
    end

    // valid bits are the only control here
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            col_valid_q <= '0;
        end else begin
            col_valid_q <= lane_ok;
        end
    end

    // positions and triangle ride along unqualified
    always_ff @(posedge clk) begin
        col_x_q <= sweep.x;
        col_y_q <= lane_y;
        col_prim_q <= sweep.prim;
    end

    assign column.x = col_x_q;
    assign column.y = col_y_q;
    assign column.valid = col_valid_q;
    assign column.prim = col_prim_q;

endmodule

`default_nettype wire

// File: source/sweep_control.sv
/* box must sit far enough inside the coordinate range that max plus four steps
   does not overflow; inputs are only sampled on the accepting edge */
`timescale 1ns/1ps
`default_nettype none

`include "raster_cfg.svh"

module sweep_control (
    input logic clk,
    input logic rst,
    input logic tri_valid,
    input sample_iter_pkg::box_t box,
    input sample_iter_pkg::prim_t prim,
    input sample_iter_pkg::sub_code_t sub_sample,
    output logic halt,
    output sample_iter_pkg::sweep_t sweep
);

    // control state
    sample_iter_pkg::sweep_state_t state_q;
    sample_iter_pkg::sweep_state_t state_nx;

    // captured triangle
    sample_iter_pkg::coord_t x_min_q;
    sample_iter_pkg::coord_t x_max_q;
    sample_iter_pkg::coord_t y_max_q;
    sample_iter_pkg::coord_t step_q;
    sample_iter_pkg::prim_t prim_q;

    // current column origin
    sample_iter_pkg::coord_t x_q;
    sample_iter_pkg::coord_t y_q;

    // candidate moves
    sample_iter_pkg::coord_t step_in;
    sample_iter_pkg::coord_t x_rt;
    sample_iter_pkg::coord_t y_up;
    logic can_right;
    logic can_up;
    logic accept;

    // one-hot code to fixed-point step, zero extended first
    assign step_in = sample_iter_pkg::coord_t'(sub_sample) << `RI_STEP_SHIFT;

    assign accept = (state_q == sample_iter_pkg::sweep_wait) && tri_valid;

    // next column right, or next row of four lanes up
    assign x_rt = x_q + step_q;
    assign y_up = y_q + (step_q << 2);
    // signed compares, box may straddle the origin
    assign can_right = (x_rt <= x_max_q);
    assign can_up = (y_up <= y_max_q);

    always_comb begin
        state_nx = state_q;
        case (state_q)
            sample_iter_pkg::sweep_wait: begin
                if (tri_valid) begin
                    state_nx = sample_iter_pkg::sweep_test;
                end
            end
            sample_iter_pkg::sweep_test: begin
                // last origin of the box, go back to waiting
                if (!can_right && !can_up) begin
                    state_nx = sample_iter_pkg::sweep_wait;
                end
            end
            default: begin
                state_nx = sample_iter_pkg::sweep_wait;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= sample_iter_pkg::sweep_wait;
        end else begin
            state_q <= state_nx;
        end
    end

    // capture on accept, then walk right-then-up
    always_ff @(posedge clk) begin
        if (accept) begin
            x_min_q <= box.x_min;
            x_max_q <= box.x_max;
            y_max_q <= box.y_max;
            step_q <= step_in;
            prim_q <= prim;
            // first origin is the lower left corner
            x_q <= box.x_min;
            y_q <= box.y_min;
        end else if (state_q == sample_iter_pkg::sweep_test) begin
            if (can_right) begin
                x_q <= x_rt;
            end else if (can_up) begin
                x_q <= x_min_q;
                y_q <= y_up;
            end
        end
    end

    // upstream holds its triangle for as long as we walk
    assign halt = (state_q == sample_iter_pkg::sweep_test);

    // origin is presented straight from the registers
    assign sweep.active = (state_q == sample_iter_pkg::sweep_test);
    assign sweep.x = x_q;
    assign sweep.y_base = y_q;
    assign sweep.step = step_q;
    assign sweep.y_max = y_max_q;
    assign sweep.prim = prim_q;

endmodule

`default_nettype wire

// File: source/sample_iter_pkg.sv
/* types shared by the iterator stages; sizes come from raster_cfg.svh */
`default_nettype none

`include "raster_cfg.svh"

package sample_iter_pkg;

    // signed fixed-point position
    typedef logic signed [`RI_SIGFIG-1:0] coord_t;
    // unsigned color channel, same word size
    typedef logic [`RI_SIGFIG-1:0] chan_t;
    // one-hot: bit 3 = 1x, bit 2 = 4x, bit 1 = 16x, bit 0 = 64x
    typedef logic [`RI_SUB_W-1:0] sub_code_t;

    typedef struct packed {
        coord_t x_min;
        coord_t y_min;
        coord_t x_max;
        coord_t y_max;
    } box_t;

    // triangle payload, carried untouched next to its samples
    typedef struct packed {
        coord_t [`RI_VERTS-1:0][`RI_AXIS-1:0] vert;
        chan_t [`RI_COLORS-1:0] color;
    } prim_t;

    // column origin from sweep_control into sample_column_gen
    typedef struct packed {
        logic active;
        coord_t x;
        coord_t y_base;
        coord_t step;
        coord_t y_max;
        prim_t prim;
    } sweep_t;

    // registered output column, lane 0 at the bottom
    typedef struct packed {
        coord_t x;
        coord_t [`RI_LANES-1:0] y;
        logic [`RI_LANES-1:0] valid;
        prim_t prim;
    } column_t;

    typedef enum logic {
        sweep_wait,
        sweep_test
    } sweep_state_t;

endpackage

`default_nettype wire

// File: source/raster_cfg.svh
/* global sizes for the sample iterator; coordinates are signed fixed point with
   RI_RADIX fraction bits, and the sub-sample code is one-hot (see package) */
`ifndef RASTER_CFG_SVH
`define RASTER_CFG_SVH

// fixed-point word, shared by coordinates and color channels
`define RI_SIGFIG 24
`define RI_RADIX 10

// triangle shape
`define RI_VERTS 3
`define RI_AXIS 3
`define RI_COLORS 3

// samples stacked in one output column
`define RI_LANES 4

// one-hot sub-sample code width
`define RI_SUB_W 4

// code bit 3 (1x) becomes one pixel, bit 0 (64x) an eighth of a pixel
`define RI_STEP_SHIFT (`RI_RADIX - 3)

`endif
